// ==== hw/qoi_defines.svh ====
`ifndef QOI_DEFINES_SVH
`define QOI_DEFINES_SVH

// Seen-pixel table and run limits
`define QOI_HASH_SIZE 64
`define QOI_RUN_MAX 62

// Default depth of the stream FIFOs
`define QOI_FIFO_DEPTH 4

// End marker is seven zero bytes and a final 0x01
`define QOI_END_BYTES 8

// Previous pixel at the start of every image, opaque black
`define QOI_START_PIXEL 32'h000000FF

// Chunk tags
`define QOI_TAG_INDEX 8'h00
`define QOI_TAG_DIFF 8'h40
`define QOI_TAG_LUMA 8'h80
`define QOI_TAG_RUN 8'hC0
`define QOI_TAG_RGB 8'hFE
`define QOI_TAG_RGBA 8'hFF

`endif

// ==== hw/qoiPkg.sv ====
package qoiPkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [7:0] a;
	} pixelT;

	// Pixel as it sits in the input FIFO
	typedef struct packed {
		pixelT pixel;
		logic last;
	} pixelBeatT;

	typedef enum logic [2:0] {
		CHUNK_NONE,
		CHUNK_INDEX,
		CHUNK_DIFF,
		CHUNK_LUMA,
		CHUNK_RGB,
		CHUNK_RGBA
	} chunkKindT;

	// Deltas carry their bias; diff uses the low two bits, luma uses dr-dg and db-dg in
	// deltaR and deltaB
	typedef struct packed {
		logic [5:0] runLength;
		chunkKindT kind;
		pixelT pixel;
		logic [5:0] index;
		logic [5:0] deltaR;
		logic [5:0] deltaG;
		logic [5:0] deltaB;
		logic last;
	} chunkT;

endpackage

// ==== hw/qoiStreamFifo.sv ====
`timescale 1ns/1ns

module qoiStreamFifo #(
	parameter type payloadT = logic [7:0],
	parameter int DEPTH = 4
) (
	input logic clk,
	input logic reset,
	input logic inValid,
	input payloadT inData,
	output logic inReady,
	output logic outValid,
	output payloadT outData,
	input logic outReady
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	payloadT mem [DEPTH];
	logic [ADDR_BITS-1:0] wrPtr;
	logic [ADDR_BITS-1:0] rdPtr;
	logic [ADDR_BITS:0] count;
	logic push;
	logic pop;

	assign inReady = (count != (ADDR_BITS + 1)'(DEPTH));
	assign outValid = (count != '0);
	assign outData = mem[rdPtr];

	assign push = inValid && inReady;
	assign pop = outValid && outReady;

	always_ff @(posedge clk) begin
		if (push)
			mem[wrPtr] <= inData;
	end

	// Pointers wrap naturally since DEPTH is a power of two
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== hw/qoiPixelClassifier.sv ====
`timescale 1ns/1ns
`include "qoi_defines.svh"

module qoiPixelClassifier import qoiPkg::*; (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input pixelT pixelData,
	input logic pixelLast,
	output logic pixelReady,
	output logic chunkValid,
	output chunkT chunkData,
	input logic chunkReady
);

	localparam int HASH_BITS = $clog2(`QOI_HASH_SIZE);

	pixelT prevPixel;
	logic [5:0] runCount;
	logic [5:0] runNext;
	pixelT seenTable [`QOI_HASH_SIZE];
	logic [`QOI_HASH_SIZE-1:0] seenValid;

	logic accept;
	logic isRepeat;
	logic indexHit;
	logic emit;
	logic [HASH_BITS-1:0] hash;
	pixelT seenEntry;
	logic signed [7:0] dr;
	logic signed [7:0] dg;
	logic signed [7:0] db;
	logic signed [7:0] dgr;
	logic signed [7:0] dgb;
	logic alphaSame;
	logic diffFits;
	logic lumaFits;
	chunkT desc;

	assign pixelReady = !chunkValid || chunkReady;
	assign accept = pixelValid && pixelReady;

	assign hash = HASH_BITS'((pixelData.r * 3 + pixelData.g * 5 + pixelData.b * 7
		+ pixelData.a * 11) % `QOI_HASH_SIZE);

	// Entries never written read as zero, like a cleared table
	assign seenEntry = seenValid[hash] ? seenTable[hash] : '0;
	assign indexHit = (seenEntry == pixelData);
	assign isRepeat = (pixelData == prevPixel);
	assign runNext = runCount + 6'd1;

	// Channel differences wrap at eight bits
	assign dr = pixelData.r - prevPixel.r;
	assign dg = pixelData.g - prevPixel.g;
	assign db = pixelData.b - prevPixel.b;
	assign dgr = dr - dg;
	assign dgb = db - dg;

	assign alphaSame = (pixelData.a == prevPixel.a);
	assign diffFits = dr >= -2 && dr <= 1 && dg >= -2 && dg <= 1 && db >= -2 && db <= 1;
	assign lumaFits = dg >= -32 && dg <= 31 && dgr >= -8 && dgr <= 7 && dgb >= -8 && dgb <= 7;

	// A pure run extension stays silent until it fills or the image ends
	assign emit = !isRepeat || pixelLast || (runNext == 6'(`QOI_RUN_MAX));

	always_comb begin
		desc = '0;
		desc.runLength = isRepeat ? runNext : runCount;
		desc.pixel = pixelData;
		desc.index = 6'(hash);
		desc.last = pixelLast;
		if (isRepeat)
			desc.kind = CHUNK_NONE;
		else if (indexHit)
			desc.kind = CHUNK_INDEX;
		else if (alphaSame && diffFits)
			desc.kind = CHUNK_DIFF;
		else if (alphaSame && lumaFits)
			desc.kind = CHUNK_LUMA;
		else if (alphaSame)
			desc.kind = CHUNK_RGB;
		else
			desc.kind = CHUNK_RGBA;
		if (desc.kind == CHUNK_LUMA) begin
			desc.deltaR = 6'(dgr + 8);
			desc.deltaG = 6'(dg + 32);
			desc.deltaB = 6'(dgb + 8);
		end else begin
			desc.deltaR = 6'(dr + 2);
			desc.deltaG = 6'(dg + 2);
			desc.deltaB = 6'(db + 2);
		end
	end

	always_ff @(posedge clk) begin
		if (accept && !isRepeat && !indexHit)
			seenTable[hash] <= pixelData;
	end

	always_ff @(posedge clk) begin
		if (accept && emit)
			chunkData <= desc;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			chunkValid <= 1'b0;
			prevPixel <= `QOI_START_PIXEL;
			runCount <= 6'd0;
			seenValid <= '0;
		end else begin
			if (accept && emit)
				chunkValid <= 1'b1;
			else if (chunkReady)
				chunkValid <= 1'b0;
			if (accept) begin
				if (pixelLast) begin
					// Next image starts from a clean encoder
					prevPixel <= `QOI_START_PIXEL;
					runCount <= 6'd0;
					seenValid <= '0;
				end else begin
					prevPixel <= pixelData;
					runCount <= emit ? 6'd0 : runNext;
					if (!isRepeat && !indexHit)
						seenValid[hash] <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/qoiChunkSerializer.sv ====
`timescale 1ns/1ns
`include "qoi_defines.svh"

module qoiChunkSerializer import qoiPkg::*; (
	input logic clk,
	input logic reset,
	input logic chunkValid,
	input chunkT chunkData,
	output logic chunkReady,
	output logic byteValid,
	output logic [7:0] byteData,
	output logic byteLast,
	input logic byteReady
);

	typedef enum logic [1:0] {
		IDLE,
		CHUNK,
		END_MARK
	} stateT;

	stateT state;
	chunkT cur;
	logic [2:0] pos;
	logic hasRun;
	logic [2:0] opCount;
	logic [2:0] byteCount;
	logic [2:0] opPos;
	logic [7:0] opByte;
	logic advance;

	assign chunkReady = (state == IDLE);
	assign byteValid = (state != IDLE);
	assign advance = byteValid && byteReady;

	// Run byte, when present, goes ahead of the op bytes
	assign hasRun = (cur.runLength != 6'd0);
	assign opPos = pos - {2'b00, hasRun};
	assign byteCount = opCount + {2'b00, hasRun};
	assign byteLast = (state == END_MARK) && (pos == 3'(`QOI_END_BYTES - 1));

	always_comb begin
		case (cur.kind)
			CHUNK_INDEX, CHUNK_DIFF: opCount = 3'd1;
			CHUNK_LUMA: opCount = 3'd2;
			CHUNK_RGB: opCount = 3'd4;
			CHUNK_RGBA: opCount = 3'd5;
			default: opCount = 3'd0;
		endcase
	end

	always_comb begin
		case (cur.kind)
			CHUNK_INDEX: opByte = `QOI_TAG_INDEX | {2'b00, cur.index};
			CHUNK_DIFF:
				opByte = `QOI_TAG_DIFF
					| {2'b00, cur.deltaR[1:0], cur.deltaG[1:0], cur.deltaB[1:0]};
			CHUNK_LUMA:
				opByte = (opPos == 3'd0) ? (`QOI_TAG_LUMA | {2'b00, cur.deltaG})
					: {cur.deltaR[3:0], cur.deltaB[3:0]};
			CHUNK_RGB, CHUNK_RGBA: begin
				case (opPos)
					3'd0: opByte = (cur.kind == CHUNK_RGBA) ? `QOI_TAG_RGBA : `QOI_TAG_RGB;
					3'd1: opByte = cur.pixel.r;
					3'd2: opByte = cur.pixel.g;
					3'd3: opByte = cur.pixel.b;
					default: opByte = cur.pixel.a;
				endcase
			end
			default: opByte = 8'h00;
		endcase
	end

	always_comb begin
		if (state == END_MARK)
			byteData = byteLast ? 8'h01 : 8'h00;
		else if (hasRun && pos == 3'd0)
			byteData = `QOI_TAG_RUN | {2'b00, cur.runLength - 6'd1};
		else
			byteData = opByte;
	end

	always_ff @(posedge clk) begin
		if (chunkValid && chunkReady)
			cur <= chunkData;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			pos <= 3'd0;
		end else begin
			case (state)
				IDLE: begin
					if (chunkValid) begin
						state <= CHUNK;
						pos <= 3'd0;
					end
				end
				CHUNK: begin
					if (advance) begin
						if (pos == byteCount - 3'd1) begin
							pos <= 3'd0;
							state <= cur.last ? END_MARK : IDLE;
						end else begin
							pos <= pos + 3'd1;
						end
					end
				end
				END_MARK: begin
					if (advance) begin
						if (byteLast) begin
							state <= IDLE;
							pos <= 3'd0;
						end else begin
							pos <= pos + 3'd1;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== hw/qoiEncoderTop.sv ====
`timescale 1ns/1ns
`include "qoi_defines.svh"

module qoiEncoderTop import qoiPkg::*; (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input pixelT pixelData,
	input logic pixelLast,
	output logic pixelReady,
	output logic byteValid,
	output logic [7:0] byteData,
	output logic byteLast,
	input logic byteReady
);

	logic beatValid;
	pixelBeatT beatData;
	logic beatReady;

	logic classChunkValid;
	chunkT classChunkData;
	logic classChunkReady;

	logic serChunkValid;
	chunkT serChunkData;
	logic serChunkReady;

	qoiStreamFifo #(
		.payloadT(pixelBeatT),
		.DEPTH(`QOI_FIFO_DEPTH)
	) pixelFifo (
		.clk(clk),
		.reset(reset),
		.inValid(pixelValid),
		.inData({pixelData, pixelLast}),
		.inReady(pixelReady),
		.outValid(beatValid),
		.outData(beatData),
		.outReady(beatReady)
	);

	qoiPixelClassifier classifier (
		.clk(clk),
		.reset(reset),
		.pixelValid(beatValid),
		.pixelData(beatData.pixel),
		.pixelLast(beatData.last),
		.pixelReady(beatReady),
		.chunkValid(classChunkValid),
		.chunkData(classChunkData),
		.chunkReady(classChunkReady)
	);

	qoiStreamFifo #(
		.payloadT(chunkT),
		.DEPTH(`QOI_FIFO_DEPTH)
	) chunkFifo (
		.clk(clk),
		.reset(reset),
		.inValid(classChunkValid),
		.inData(classChunkData),
		.inReady(classChunkReady),
		.outValid(serChunkValid),
		.outData(serChunkData),
		.outReady(serChunkReady)
	);

	qoiChunkSerializer serializer (
		.clk(clk),
		.reset(reset),
		.chunkValid(serChunkValid),
		.chunkData(serChunkData),
		.chunkReady(serChunkReady),
		.byteValid(byteValid),
		.byteData(byteData),
		.byteLast(byteLast),
		.byteReady(byteReady)
	);

endmodule

// ==== sim/qoiEncoder_props.sv ====
`timescale 1ns/1ns

module qoiEncoderProps import qoiPkg::*; (
	input logic clk,
	input logic reset,
	input logic pixelValid,
	input logic pixelReady,
	input logic chunkValid,
	input chunkT chunkData,
	input logic chunkReady,
	input logic byteValid,
	input logic [7:0] byteData,
	input logic byteLast,
	input logic byteReady
);

	int failCount = 0;

	// Output byte holds while the sink stalls
	byteHold: assert property (@(posedge clk) disable iff (reset)
		byteValid && !byteReady |=> byteValid && $stable(byteData) && $stable(byteLast))
	else begin
		failCount++;
		$error("byte stream changed while byteReady was low");
	end

	// Input FIFO only loses space through a push
	pixelReadyHold: assert property (@(posedge clk) disable iff (reset)
		pixelReady && !pixelValid |=> pixelReady)
	else begin
		failCount++;
		$error("pixelReady dropped without a pixel transfer");
	end

	chunkHold: assert property (@(posedge clk) disable iff (reset)
		chunkValid && !chunkReady |=> chunkValid && $stable(chunkData))
	else begin
		failCount++;
		$error("classifier descriptor changed while the chunk FIFO was full");
	end

	resetQuiet: assert property (@(posedge clk) reset |-> !byteValid)
	else begin
		failCount++;
		$error("byteValid high during reset");
	end

	resetRelease: assert property (@(posedge clk) $fell(reset) |-> !byteValid)
	else begin
		failCount++;
		$error("byteValid high right after reset");
	end

endmodule

bind qoiEncoderTop qoiEncoderProps props (
	.clk(clk),
	.reset(reset),
	.pixelValid(pixelValid),
	.pixelReady(pixelReady),
	.chunkValid(classChunkValid),
	.chunkData(classChunkData),
	.chunkReady(classChunkReady),
	.byteValid(byteValid),
	.byteData(byteData),
	.byteLast(byteLast),
	.byteReady(byteReady)
);

// ==== sim/qoiEncoderTb.sv ====
`timescale 1ns/1ns
`include "qoi_defines.svh"

module qoiEncoderTb import qoiPkg::*; ();

	localparam int PERIOD = 4;
	localparam int RESET_CYCLES = 8;
	localparam int TOTAL_PIXELS = 150 + 100 + 48 + 120 + 120 + 80;
	localparam int IMAGES = 7;
	localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 6 * 4 + IMAGES * `QOI_END_BYTES
		+ RESET_CYCLES;

	logic clk;
	logic reset;
	logic pixelValid;
	pixelT pixelData;
	logic pixelLast;
	logic pixelReady;
	logic byteValid;
	logic [7:0] byteData;
	logic byteLast;
	logic byteReady;

	logic [31:0] lfsrState = 32'd95953;
	logic stallOn = 1'b0;
	pixelT image[$];
	logic [7:0] expByte[$];
	logic expLast[$];
	string expName[$];
	int bytesChecked = 0;

	qoiEncoderTop uut (
		.clk(clk),
		.reset(reset),
		.pixelValid(pixelValid),
		.pixelData(pixelData),
		.pixelLast(pixelLast),
		.pixelReady(pixelReady),
		.byteValid(byteValid),
		.byteData(byteData),
		.byteLast(byteLast),
		.byteReady(byteReady)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	task automatic stopWithFailure(input string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at first failure");
	endtask

	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic lfsrStep();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < count; k++)
			value = {value[30:0], lfsrStep()};
		return value;
	endfunction

	task automatic pushByte(input logic [7:0] value, input logic last, input string name);
		expByte.push_back(value);
		expLast.push_back(last);
		expName.push_back(name);
	endtask

	// Reference QOI encoding of the current image, from a clean encoder state
	task automatic modelEncode(input string name);
		pixelT seen [`QOI_HASH_SIZE];
		pixelT prev;
		pixelT px;
		int run;
		int h;
		int dr, dg, db;
		int dgr, dgb;
		foreach (seen[k])
			seen[k] = '0;
		prev = `QOI_START_PIXEL;
		run = 0;
		for (int i = 0; i < image.size(); i++) begin
			px = image[i];
			if (px == prev) begin
				run++;
				if (run == `QOI_RUN_MAX || i == image.size() - 1) begin
					pushByte(8'(`QOI_TAG_RUN + run - 1), 1'b0, name);
					run = 0;
				end
			end else begin
				if (run > 0) begin
					pushByte(8'(`QOI_TAG_RUN + run - 1), 1'b0, name);
					run = 0;
				end
				h = (px.r * 3 + px.g * 5 + px.b * 7 + px.a * 11) % `QOI_HASH_SIZE;
				dr = $signed(8'(px.r - prev.r));
				dg = $signed(8'(px.g - prev.g));
				db = $signed(8'(px.b - prev.b));
				dgr = $signed(8'(dr - dg));
				dgb = $signed(8'(db - dg));
				if (seen[h] == px) begin
					pushByte(8'(`QOI_TAG_INDEX + h), 1'b0, name);
				end else begin
					seen[h] = px;
					if (px.a == prev.a && dr >= -2 && dr <= 1 && dg >= -2 && dg <= 1
						&& db >= -2 && db <= 1) begin
						pushByte(8'(`QOI_TAG_DIFF + (dr + 2) * 16 + (dg + 2) * 4 + db + 2),
							1'b0, name);
					end else if (px.a == prev.a && dg >= -32 && dg <= 31 && dgr >= -8
						&& dgr <= 7 && dgb >= -8 && dgb <= 7) begin
						pushByte(8'(`QOI_TAG_LUMA + dg + 32), 1'b0, name);
						pushByte(8'((dgr + 8) * 16 + dgb + 8), 1'b0, name);
					end else begin
						pushByte(px.a == prev.a ? `QOI_TAG_RGB : `QOI_TAG_RGBA, 1'b0, name);
						pushByte(px.r, 1'b0, name);
						pushByte(px.g, 1'b0, name);
						pushByte(px.b, 1'b0, name);
						if (px.a != prev.a)
							pushByte(px.a, 1'b0, name);
					end
				end
			end
			prev = px;
		end
		for (int k = 0; k < `QOI_END_BYTES - 1; k++)
			pushByte(8'h00, 1'b0, name);
		pushByte(8'h01, 1'b1, name);
	endtask

	// Opaque black matches the start pixel, so the image is all runs
	task automatic buildSolid();
		image.delete();
		repeat (150) image.push_back(`QOI_START_PIXEL);
	endtask

	task automatic buildGradient();
		pixelT px;
		int step;
		image.delete();
		px = 32'h0A0A0AFF;
		for (int i = 0; i < 100; i++) begin
			step = (i % 5 == 4) ? 12 : (i % 3) - 1;
			px.g = px.g + 8'(step);
			px.r = px.r + 8'(step + (i % 4) - 2);
			px.b = px.b + 8'(step + 1 - (i % 3));
			image.push_back(px);
		end
	endtask

	task automatic buildPalette();
		pixelT colors[4];
		image.delete();
		colors[0] = 32'h1080F0FF;
		colors[1] = 32'hC02040FF;
		colors[2] = 32'h33991180;
		colors[3] = 32'hEEEE0020;
		for (int i = 0; i < 48; i++)
			image.push_back(colors[i % 4]);
	endtask

	// One pixel in eight repeats and a quarter of new pixels change alpha
	task automatic buildRandom(input int count);
		pixelT px;
		image.delete();
		px = `QOI_START_PIXEL;
		for (int i = 0; i < count; i++) begin
			if (randomBits(3) != 0) begin
				px.r = 8'(randomBits(8));
				px.g = 8'(randomBits(8));
				px.b = 8'(randomBits(8));
				if (randomBits(2) == 0)
					px.a = 8'(randomBits(8));
			end
			image.push_back(px);
		end
	endtask

	// Starts at the next falling edge and returns at the falling edge after the last transfer
	task automatic sendImage();
		@(negedge clk);
		for (int i = 0; i < image.size(); i++) begin
			pixelValid = 1'b1;
			pixelData = image[i];
			pixelLast = (i == image.size() - 1);
			while (!pixelReady)
				@(negedge clk);
			@(negedge clk);
		end
		pixelValid = 1'b0;
		pixelLast = 1'b0;
	endtask

	// Returns on a rising edge, where the sink never runs
	task automatic waitForOutput();
		while (expByte.size() != 0)
			@(posedge clk);
	endtask

	task automatic checkByte();
		if (expByte.size() == 0) begin
			stopWithFailure("A byte came out of the encoder with no byte expected");
		end else begin
			assert (byteData == expByte[0])
			else stopWithFailure($sformatf("ERROR %s: byte %0d expected %02h, actual %02h",
				expName[0], bytesChecked, expByte[0], byteData));
			assert (byteLast == expLast[0])
			else stopWithFailure($sformatf("ERROR %s: byteLast %0d expected %0b, actual %0b",
				expName[0], bytesChecked, expLast[0], byteLast));
			void'(expByte.pop_front());
			void'(expLast.pop_front());
			void'(expName.pop_front());
			bytesChecked++;
		end
	endtask

	// Sink draws byteReady and checks the byte at the falling edge
	initial begin
		forever begin
			@(negedge clk);
			byteReady = stallOn ? lfsrStep() : 1'b1;
			if (!reset && byteValid && byteReady)
				checkByte();
		end
	end

	initial begin
		forever begin
			@(negedge clk);
			if (uut.props.failCount != 0)
				stopWithFailure("A stream handshake assertion failed");
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		stopWithFailure("The run timed out before every byte was checked");
	end

	initial begin
		reset = 1'b1;
		pixelValid = 1'b0;
		pixelData = '0;
		pixelLast = 1'b0;
		byteReady = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		buildSolid();
		modelEncode("solid run");
		sendImage();
		waitForOutput();

		buildGradient();
		modelEncode("gradient");
		sendImage();
		waitForOutput();

		buildPalette();
		modelEncode("palette index");
		sendImage();
		waitForOutput();

		buildRandom(120);
		modelEncode("random rgb rgba");
		sendImage();
		waitForOutput();

		// Same pixels again with a random stall on the byte stream
		stallOn = 1'b1;
		modelEncode("stalled output");
		sendImage();
		waitForOutput();
		stallOn = 1'b0;

		// Identical images back to back only match if the encoder restarts cleanly
		buildRandom(35);
		repeat (5) image.push_front(`QOI_START_PIXEL);
		modelEncode("back to back first");
		modelEncode("back to back second");
		sendImage();
		sendImage();
		waitForOutput();
		@(negedge clk);

		if (uut.props.failCount == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			stopWithFailure("A stream handshake assertion failed");
		end
	end

endmodule

// ==== qoiEncoderTop.f ====
+incdir+hw
hw/qoiPkg.sv
hw/qoiStreamFifo.sv
hw/qoiPixelClassifier.sv
hw/qoiChunkSerializer.sv
hw/qoiEncoderTop.sv
sim/qoiEncoder_props.sv
sim/qoiEncoderTb.sv

// ==== Makefile ====
TOP = qoiEncoderTb
SOURCES = $(wildcard hw/*.sv hw/*.svh sim/*.sv) qoiEncoderTop.f

.PHONY: all run clean

all: run

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f qoiEncoderTop.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
